// ==== files.f ====
hdl/busPkg.sv
hdl/tubePkg.sv
hdl/tubeRegisterFile.sv
hdl/scanTimer.sv
hdl/scanController.sv
hdl/segmentDecoder.sv
hdl/digitalTubeTop.sv
verification/digitalTube_properties.sv
verification/digitalTubeTb.sv

// ==== hdl/busPkg.sv ====
package busPkg;

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite widths for the display peripheral
    //////////////////////////////////////////////////////////////////////

    localparam int AXI_ADDRESS_WIDTH = 4;                 // 16-byte window
    localparam int AXI_DATA_WIDTH    = 32;
    localparam int AXI_STROBE_WIDTH  = AXI_DATA_WIDTH / 8;

    // Only the two codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10        // Unmapped address
    } axiResponseCode;

    // Manager-driven signals
    typedef struct packed {
        logic [AXI_ADDRESS_WIDTH-1:0] awAddress;
        logic                         awValid;
        logic [AXI_DATA_WIDTH-1:0]    wData;
        logic [AXI_STROBE_WIDTH-1:0]  wStrobe;
        logic                         wValid;
        logic                         bReady;
        logic [AXI_ADDRESS_WIDTH-1:0] arAddress;
        logic                         arValid;
        logic                         rReady;
    } axiLiteRequest;

    // Subordinate-driven signals
    typedef struct packed {
        logic                      awReady;
        logic                      wReady;
        logic                      bValid;
        axiResponseCode            bResponse;
        logic                      arReady;
        logic [AXI_DATA_WIDTH-1:0] rData;
        logic                      rValid;
        axiResponseCode            rResponse;
    } axiLiteResponse;

endpackage

// ==== hdl/digitalTubeTop.sv ====
`timescale 1ns/1ns

module digitalTubeTop import busPkg::*, tubePkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  axiLiteRequest  busRequest,
    output axiLiteResponse busResponse,
    output tubeDrive       drive
);

    displayRegisters              registers;
    logic                         tick;
    logic [DIGIT_INDEX_WIDTH-1:0] digitIndex;
    logic                         showDigit;

    // Bus side
    tubeRegisterFile registerFile_i (
        .clock       (clock),
        .reset       (reset),
        .busRequest  (busRequest),
        .busResponse (busResponse),
        .registers   (registers)
    );

    ///////////////////////////////////////////////////////////////////////
    // Display scan
    ///////////////////////////////////////////////////////////////////////

    scanTimer scanTimer_i (
        .clock (clock),
        .reset (reset),
        .tick  (tick)
    );

    scanController scanController_i (
        .clock      (clock),
        .reset      (reset),
        .tick       (tick),
        .digitIndex (digitIndex),
        .showDigit  (showDigit)
    );

    segmentDecoder segmentDecoder_i (
        .clock      (clock),
        .reset      (reset),
        .registers  (registers),
        .digitIndex (digitIndex),
        .showDigit  (showDigit),
        .drive      (drive)
    );

endmodule

// ==== hdl/scanController.sv ====
`timescale 1ns/1ns

module scanController import tubePkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         tick,
    output logic [DIGIT_INDEX_WIDTH-1:0] digitIndex,
    output logic                         showDigit
);

    scanState state;
    scanState nextState;
    logic [DIGIT_INDEX_WIDTH-1:0] nextIndex;

    ///////////////////////////////////////////////////////////////////////
    // Next state
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        nextIndex = digitIndex;
        case (state)
            scanIdle: begin
                if (tick) begin
                    nextState = scanBlank;
                    nextIndex = '0;                 // Scan always starts at digit 0
                end
            end
            scanBlank: begin
                nextState = scanShow;               // One clock of blanking
            end
            scanShow: begin
                if (tick) begin
                    nextState = scanBlank;
                    if (digitIndex == DIGIT_INDEX_WIDTH'(DIGIT_COUNT - 1)) begin
                        nextIndex = '0;
                    end else begin
                        nextIndex = digitIndex + 1'b1;
                    end
                end
            end
            default: begin
                nextState = scanIdle;
            end
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // State and index registers
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= scanIdle;
            digitIndex <= '0;
        end else begin
            state      <= nextState;
            digitIndex <= nextIndex;
        end
    end

    // Gap state keeps the old glyph off the next anode
    assign showDigit = (state == scanShow);

endmodule

// ==== hdl/scanTimer.sv ====
`timescale 1ns/1ns

module scanTimer import tubePkg::*; (
    input  logic clock,
    input  logic reset,
    output logic tick
);

    logic [SCAN_COUNTER_WIDTH-1:0] count;
    logic                          expired;

    assign expired = (count == '0);

    // Down-counter, reloads each slot
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= SCAN_COUNTER_WIDTH'(SCAN_DIVIDE - 1);
        end else if (expired) begin
            count <= SCAN_COUNTER_WIDTH'(SCAN_DIVIDE - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    // Registered so the first pulse lands SCAN_DIVIDE clocks after reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= expired;
        end
    end

endmodule

// ==== hdl/segmentDecoder.sv ====
`timescale 1ns/1ns

module segmentDecoder import tubePkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    input  displayRegisters              registers,
    input  logic [DIGIT_INDEX_WIDTH-1:0] digitIndex,
    input  logic                         showDigit,
    output tubeDrive                     drive
);

    logic [2*REGISTER_WIDTH-1:0] allDigits;
    logic [3:0] nibble;
    logic       decimalPoint;
    logic       digitEnabled;
    logic [6:0] glyph;                                  // A..G, active high

    assign allDigits    = {registers.highData, registers.lowData};
    assign nibble       = allDigits[digitIndex*4 +: 4];
    assign decimalPoint = registers.specialDisplay[digitIndex];
    assign digitEnabled = registers.specialDisplay[DIGIT_COUNT + digitIndex];

    always_comb begin
        case (nibble)
            4'h0: glyph = 7'b1111110;
            4'h1: glyph = 7'b0110000;
            4'h2: glyph = 7'b1101101;
            4'h3: glyph = 7'b1111001;
            4'h4: glyph = 7'b0110011;
            4'h5: glyph = 7'b1011011;
            4'h6: glyph = 7'b1011111;
            4'h7: glyph = 7'b1110000;
            4'h8: glyph = 7'b1111111;
            4'h9: glyph = 7'b1111011;
            4'hA: glyph = 7'b1110111;
            4'hB: glyph = 7'b0011111;                   // Lower-case b
            4'hC: glyph = 7'b1001110;
            4'hD: glyph = 7'b0111101;                   // Lower-case d
            4'hE: glyph = 7'b1001111;
            default: glyph = 7'b1000111;                // F
        endcase
    end

    // Output register, one anode low at most
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            drive <= DRIVE_BLANK;
        end else if (showDigit && digitEnabled) begin
            drive.anodeEnable <= ~(DIGIT_COUNT'(1) << digitIndex);
            drive.segments    <= ~{glyph, decimalPoint};
        end else begin
            drive <= DRIVE_BLANK;
        end
    end

endmodule

// ==== hdl/tubePkg.sv ====
package tubePkg;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam logic [3:0] LOW_DATA_ADDRESS  = 4'h0;     // Digits 0 to 3
    localparam logic [3:0] HIGH_DATA_ADDRESS = 4'h4;     // Digits 4 to 7
    localparam logic [3:0] SPECIAL_ADDRESS   = 4'h8;     // DP bits and enable mask

    localparam int REGISTER_WIDTH = 16;
    localparam int REGISTER_BYTES = REGISTER_WIDTH / 8;

    //////////////////////////////////////////////////////////////////////
    // Scan parameters
    //////////////////////////////////////////////////////////////////////

    localparam int DIGIT_COUNT        = 8;
    localparam int DIGIT_INDEX_WIDTH  = $clog2(DIGIT_COUNT);
    localparam int SCAN_DIVIDE        = 64;               // Clocks per digit slot
    localparam int SCAN_COUNTER_WIDTH = $clog2(SCAN_DIVIDE);

    typedef struct packed {
        logic [REGISTER_WIDTH-1:0] specialDisplay;    // [15:8] enable mask, [7:0] DP
        logic [REGISTER_WIDTH-1:0] highData;
        logic [REGISTER_WIDTH-1:0] lowData;
    } displayRegisters;

    typedef enum logic [1:0] {
        scanIdle,
        scanBlank,
        scanShow
    } scanState;

    // Both fields active low
    typedef struct packed {
        logic [DIGIT_COUNT-1:0] anodeEnable;
        logic [7:0]             segments;    // [7:1] A to G, [0] DP
    } tubeDrive;

    // Every anode and segment off
    localparam tubeDrive DRIVE_BLANK = '{anodeEnable: '1, segments: '1};

endpackage

// ==== hdl/tubeRegisterFile.sv ====
`timescale 1ns/1ns

module tubeRegisterFile import busPkg::*, tubePkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  axiLiteRequest   busRequest,
    output axiLiteResponse  busResponse,
    output displayRegisters registers
);

    logic writeAccept;
    logic readAccept;
    logic writeMapped;
    logic readMapped;
    logic [REGISTER_WIDTH-1:0] readValue;
    logic [REGISTER_WIDTH-1:0] writeValue;

    // Response channel state
    logic                      bValid;
    axiResponseCode            bResponse;
    logic                      rValid;
    logic [AXI_DATA_WIDTH-1:0] rData;
    axiResponseCode            rResponse;

    function automatic logic isMapped(input logic [AXI_ADDRESS_WIDTH-1:0] address);
        return address inside {LOW_DATA_ADDRESS, HIGH_DATA_ADDRESS, SPECIAL_ADDRESS};
    endfunction

    // Byte-wise merge of new data into a 16-bit register
    function automatic logic [REGISTER_WIDTH-1:0] mergeBytes(
        input logic [REGISTER_WIDTH-1:0] current,
        input logic [REGISTER_WIDTH-1:0] data,
        input logic [REGISTER_BYTES-1:0] strobe
    );
        logic [REGISTER_WIDTH-1:0] merged;
        merged = current;
        for (int i = 0; i < REGISTER_BYTES; i++) begin
            if (strobe[i]) begin
                merged[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Handshake
    ///////////////////////////////////////////////////////////////////////

    // Address and data taken together, never while a response waits
    assign writeAccept = busRequest.awValid && busRequest.wValid && !bValid;
    assign readAccept  = busRequest.arValid && !rValid;

    assign writeMapped = isMapped(busRequest.awAddress);
    assign readMapped  = isMapped(busRequest.arAddress);

    always_comb begin
        busResponse           = '0;
        busResponse.awReady   = writeAccept;
        busResponse.wReady    = writeAccept;
        busResponse.bValid    = bValid;
        busResponse.bResponse = bResponse;
        busResponse.arReady   = readAccept;
        busResponse.rData     = rData;
        busResponse.rValid    = rValid;
        busResponse.rResponse = rResponse;
    end

    ///////////////////////////////////////////////////////////////////////
    // Write path
    ///////////////////////////////////////////////////////////////////////

    assign writeValue = busRequest.wData[REGISTER_WIDTH-1:0];   // Upper half ignored

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bValid    <= 1'b0;
            registers <= '0;
        end else begin
            if (writeAccept) begin
                bValid <= 1'b1;
                case (busRequest.awAddress)
                    LOW_DATA_ADDRESS: registers.lowData <= mergeBytes(registers.lowData,
                        writeValue, busRequest.wStrobe[REGISTER_BYTES-1:0]);
                    HIGH_DATA_ADDRESS: registers.highData <= mergeBytes(registers.highData,
                        writeValue, busRequest.wStrobe[REGISTER_BYTES-1:0]);
                    SPECIAL_ADDRESS: registers.specialDisplay <= mergeBytes(
                        registers.specialDisplay, writeValue,
                        busRequest.wStrobe[REGISTER_BYTES-1:0]);
                    default: ;                  // Unmapped, nothing written
                endcase
            end else if (bValid && busRequest.bReady) begin
                bValid <= 1'b0;
            end
        end
    end

    // Code held until the manager takes it
    always_ff @(posedge clock) begin
        if (writeAccept) begin
            bResponse <= writeMapped ? OKAY : SLVERR;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Read path
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        case (busRequest.arAddress)
            LOW_DATA_ADDRESS:  readValue = registers.lowData;
            HIGH_DATA_ADDRESS: readValue = registers.highData;
            SPECIAL_ADDRESS:   readValue = registers.specialDisplay;
            default:           readValue = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rValid <= 1'b0;
        end else if (readAccept) begin
            rValid <= 1'b1;
        end else if (rValid && busRequest.rReady) begin
            rValid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (readAccept) begin
            rData     <= AXI_DATA_WIDTH'(readValue);   // Zero-extended
            rResponse <= readMapped ? OKAY : SLVERR;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert -Wno-fatal --top-module digitalTubeTb -f files.f -o digitalTubeSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/digitalTubeSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Simulation finished: FAIL" "$logFile"; then
    echo "Testbench reported a failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$logFile"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== verification/digitalTubeTb.sv ====
`timescale 1ns/1ns

module digitalTubeTb import busPkg::*, tubePkg::*; ();

    localparam int ACCESS_ROUNDS   = 40;
    localparam int UNMAPPED_ROUNDS = 8;
    localparam int FRAME_ROUNDS    = 3;
    localparam int MAX_HOLD        = 8;                 // Longest ready stall
    localparam int FRAME_CLOCKS    = DIGIT_COUNT * SCAN_DIVIDE;
    localparam int TRANSFERS = 2 * ACCESS_ROUNDS + 3 * UNMAPPED_ROUNDS + 3 * FRAME_ROUNDS + 1;
    localparam int TIMEOUT_CLOCKS  = 30 * FRAME_CLOCKS + 40 * TRANSFERS;
    localparam logic [3:0] MAPPED [3] = '{LOW_DATA_ADDRESS, HIGH_DATA_ADDRESS, SPECIAL_ADDRESS};

    // Standard hex glyphs, A in bit 6 down to G in bit 0
    localparam logic [6:0] HEX_GLYPH [16] = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B,
        7'h5F, 7'h70, 7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47};

    logic           clock = 1'b0;
    logic           reset;
    axiLiteRequest  busRequest;
    axiLiteResponse busResponse;
    tubeDrive       drive;

    logic [REGISTER_WIDTH-1:0] model [3];               // Low, high, special
    logic [DIGIT_COUNT-1:0]    shownMask;
    int cycleCount      = 0;
    int lastAcceptCycle = -100;
    int litDigit        = -1;                           // Last digit seen lit

    digitalTubeTop digitalTubeTop_i (
        .clock       (clock),
        .reset       (reset),
        .busRequest  (busRequest),
        .busResponse (busResponse),
        .drive       (drive)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CLOCKS) begin
            $display("Timeout after %0d clocks, the test hung", cycleCount);
            $display("Simulation finished: FAIL");
            $fatal(1, "Run limit reached");
        end
    end

    task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
                              input string message);
        if (expected !== actual) begin
            $display("[FAIL] %0t ns: %s, expected 0x%0h, got 0x%0h",
                     $time, message, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic int registerIndex(input logic [3:0] address);
        case (address)
            LOW_DATA_ADDRESS:  return 0;
            HIGH_DATA_ADDRESS: return 1;
            SPECIAL_ADDRESS:   return 2;
            default:           return -1;
        endcase
    endfunction

    function automatic int nextEnabledDigit(input int digit);
        for (int step = 1; step <= DIGIT_COUNT; step++) begin
            if (model[2][DIGIT_COUNT + (digit + step) % DIGIT_COUNT]) begin
                return (digit + step) % DIGIT_COUNT;
            end
        end
        return digit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Display monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin : driveMonitor
        int lowCount;
        int lit;
        logic [3:0] nibble;
        logic [7:0] segments;
        if (!reset && cycleCount - lastAcceptCycle > 2 && drive.anodeEnable != '1) begin
            lowCount = 0;
            lit = 0;
            for (int d = 0; d < DIGIT_COUNT; d++) begin
                if (!drive.anodeEnable[d]) begin
                    lowCount++;
                    lit = d;
                end
            end
            nibble   = (lit < 4) ? model[0][lit*4 +: 4] : model[1][(lit-4)*4 +: 4];
            segments = ~{HEX_GLYPH[nibble], model[2][lit]};     // Active low
            checkValue(1, lowCount, "number of anodes low");
            checkValue(1, model[2][DIGIT_COUNT + lit], "enable bit of the lit digit");
            checkValue(segments, drive.segments, $sformatf("segments of digit %0d", lit));
            if (lit != litDigit) begin
                if (litDigit >= 0) begin
                    checkValue(nextEnabledDigit(litDigit), lit, "next digit in scan order");
                end
                litDigit = lit;
            end
            shownMask[lit] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite manager
    //////////////////////////////////////////////////////////////////////

    task automatic busWrite(input logic [3:0] address, input logic [31:0] data,
                            input logic [3:0] strobe, output axiResponseCode response);
        int hold;
        int index;
        hold = $urandom_range(0, MAX_HOLD);
        @(negedge clock);
        busRequest.awAddress = address;
        busRequest.awValid   = 1'b1;
        busRequest.wData     = data;
        busRequest.wStrobe   = strobe;
        busRequest.wValid    = 1'b1;
        @(negedge clock);
        while (!busResponse.bValid) @(negedge clock);
        lastAcceptCycle = cycleCount;
        index = registerIndex(address);
        if (index >= 0) begin
            for (int b = 0; b < REGISTER_BYTES; b++) begin
                if (strobe[b]) model[index][b*8 +: 8] = data[b*8 +: 8];
            end
            if (index == 2) litDigit = -1;                      // Mask may have changed
        end
        response = busResponse.bResponse;
        busRequest.wData = ~data;                   // Second write offered under stall
        repeat (hold) begin
            checkValue(0, busResponse.awReady, "write accepted while bValid waits");
            checkValue(0, busResponse.wReady, "write data accepted while bValid waits");
            checkValue(1, busResponse.bValid, "bValid held until bReady");
            checkValue(response, busResponse.bResponse, "write response code while waiting");
            @(negedge clock);
        end
        busRequest.awValid = 1'b0;
        busRequest.wValid  = 1'b0;
        busRequest.bReady  = 1'b1;
        @(negedge clock);
        checkValue(0, busResponse.bValid, "bValid after bReady");
        busRequest.bReady = 1'b0;
    endtask

    task automatic busRead(input logic [3:0] address, output logic [31:0] data,
                           output axiResponseCode response);
        int hold;
        hold = $urandom_range(0, MAX_HOLD);
        @(negedge clock);
        busRequest.arAddress = address;
        busRequest.arValid   = 1'b1;
        @(negedge clock);
        while (!busResponse.rValid) @(negedge clock);
        data     = busResponse.rData;
        response = busResponse.rResponse;
        repeat (hold) begin
            checkValue(0, busResponse.arReady, "read accepted while rValid waits");
            checkValue(1, busResponse.rValid, "rValid held until rReady");
            checkValue(data, busResponse.rData, "read data while waiting");
            checkValue(response, busResponse.rResponse, "read response code while waiting");
            @(negedge clock);
        end
        busRequest.arValid = 1'b0;
        busRequest.rReady  = 1'b1;
        @(negedge clock);
        checkValue(0, busResponse.rValid, "rValid after rReady");
        busRequest.rReady = 1'b0;
    endtask

    task automatic readBack(input logic [3:0] address);
        logic [31:0]    data;
        axiResponseCode response;
        busRead(address, data, response);
        checkValue(OKAY, response, "read response code");
        checkValue({16'h0, model[registerIndex(address)]}, data, "read-back data");
    endtask

    initial begin : stimulus
        logic [3:0]     address;
        logic [31:0]    readData;
        axiResponseCode response;
        void'($urandom(32'h3536_9c55));
        busRequest = '0;
        reset      = 1'b1;
        model      = '{3{16'h0}};
        shownMask  = '0;
        repeat (2) @(negedge clock);
        reset = 1'b0;

        repeat (SCAN_DIVIDE / 2) begin                          // Before the first tick
            @(negedge clock);
            checkValue(DRIVE_BLANK, drive, "drive after reset");
            checkValue(0, busResponse.bValid, "bValid after reset");
            checkValue(0, busResponse.rValid, "rValid after reset");
        end

        repeat (ACCESS_ROUNDS) begin
            busWrite(MAPPED[$urandom_range(0, 2)], $urandom, 4'($urandom_range(0, 15)),
                     response);
            checkValue(OKAY, response, "write response code");
            readBack(MAPPED[$urandom_range(0, 2)]);
        end

        repeat (UNMAPPED_ROUNDS) begin
            address = LOW_DATA_ADDRESS;
            while (registerIndex(address) >= 0) begin
                address = 4'($urandom);
            end
            busWrite(address, $urandom, 4'hF, response);
            checkValue(SLVERR, response, "write response code of unmapped address");
            busRead(address, readData, response);
            checkValue(SLVERR, response, "read response code of unmapped address");
            checkValue(0, readData, "read data of unmapped address");
            readBack(MAPPED[$urandom_range(0, 2)]);
        end

        repeat (FRAME_ROUNDS) begin
            busWrite(LOW_DATA_ADDRESS, $urandom, 4'h3, response);
            busWrite(HIGH_DATA_ADDRESS, $urandom, 4'h3, response);
            busWrite(SPECIAL_ADDRESS, $urandom, 4'h3, response);
            shownMask = '0;
            repeat (FRAME_CLOCKS + SCAN_DIVIDE) @(negedge clock);
            checkValue(model[2][15:8], shownMask, "digits shown in one frame");
        end

        busWrite(SPECIAL_ADDRESS, 32'($urandom_range(0, 255)), 4'h3, response);
        repeat (FRAME_CLOCKS) begin
            @(negedge clock);
            checkValue({DIGIT_COUNT{1'b1}}, drive.anodeEnable, "anodes with a mask of zero");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verification/digitalTube_properties.sv ====
`timescale 1ns/1ns

module digitalTube_properties import busPkg::*, tubePkg::*; (
    input logic           clock,
    input logic           reset,
    input axiLiteRequest  busRequest,
    input axiLiteResponse busResponse,
    input tubeDrive       drive
);

    // Common anode, two low anodes would mix two glyphs
    assert property (@(posedge clock) disable iff (reset)
        $countones(~drive.anodeEnable) <= 1)
        else $error("More than one anode enabled at once");

    assert property (@(posedge clock) disable iff (reset)
        busResponse.bValid && !busRequest.bReady |=>
            busResponse.bValid && $stable(busResponse.bResponse))
        else $error("Write response dropped or changed before bReady");

    assert property (@(posedge clock) disable iff (reset)
        busResponse.rValid && !busRequest.rReady |=>
            busResponse.rValid && $stable(busResponse.rData) && $stable(busResponse.rResponse))
        else $error("Read data dropped or changed before rReady");

    assert property (@(posedge clock) reset |=> drive == DRIVE_BLANK)
        else $error("Display drive not blank during reset");

endmodule

bind digitalTubeTop digitalTube_properties digitalTubeProperties_i (
    .clock       (clock),
    .reset       (reset),
    .busRequest  (busRequest),
    .busResponse (busResponse),
    .drive       (drive)
);
